/* src/tensor_params.svh */
// Video tensor parameters
// Dimension extent and pixel, sum and coordinate widths
`ifndef TENSOR_PARAMS_SVH
`define TENSOR_PARAMS_SVH

// Extent of batch, frame, channel, row and col
`define TENSOR_DIM 4

// Bits per dimension index
`define COORD_W 2

// Stored pixel width
`define PIXEL_W 8

// Read result width, wide enough for a five-pixel sum
`define SUM_W 16

`endif

/* src/tensor_pkg.sv */
// Video tensor types
// Coordinates, write requests, stencil windows and configuration
`include "tensor_params.svh"

package tensor_pkg;

    // One index per dimension, batch is most significant
    typedef struct packed {
        logic [`COORD_W-1:0] batch;
        logic [`COORD_W-1:0] frame;
        logic [`COORD_W-1:0] channel;
        logic [`COORD_W-1:0] row;
        logic [`COORD_W-1:0] col;
    } tensor_coord_t;

    // Write request into the store
    typedef struct packed {
        tensor_coord_t       coord;
        logic [`PIXEL_W-1:0] pixel;
    } tensor_wr_t;

    // Center pixel plus its four spatial neighbors
    typedef struct packed {
        logic [`PIXEL_W-1:0] center;
        logic [`PIXEL_W-1:0] up;    // row - 1
        logic [`PIXEL_W-1:0] down;  // row + 1
        logic [`PIXEL_W-1:0] left;  // col - 1
        logic [`PIXEL_W-1:0] right; // col + 1
    } stencil_win_t;

    // Configuration register contents
    typedef struct packed {
        logic                stencil_en;
        logic [`PIXEL_W-1:0] fill_offset;
    } tensor_cfg_t;

endpackage

/* src/tensor_cfg_regs.sv */
// Configuration registers
// Stencil enable at address 0, fill offset at address 1
`timescale 1ns/1ps

module tensor_cfg_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_wr,
    input  logic                    cfg_addr,
    input  logic [7:0]              cfg_wdata,
    output tensor_pkg::tensor_cfg_t cfg
);

    localparam logic ADDR_CTRL   = 1'b0;
    localparam logic ADDR_OFFSET = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (cfg_wr) begin
            case (cfg_addr)
                ADDR_CTRL: begin
                    cfg.stencil_en <= cfg_wdata[0]; // Upper bits ignored
                end
                ADDR_OFFSET: begin
                    cfg.fill_offset <= cfg_wdata;
                end
            endcase
        end
    end

    // Nothing to decode beyond the two addresses
    // Fill offset is used on the next fill sweep, not retroactively

endmodule

/* src/fill_engine.sv */
// Pattern fill engine
// Sweeps every coordinate once with a linear pattern, else passes host writes
`timescale 1ns/1ps
`include "tensor_params.svh"

module fill_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fill_start,
    input  logic [7:0]             fill_offset,
    input  logic                   host_wr,
    input  tensor_pkg::tensor_wr_t host_wr_req,
    output logic                   fill_busy,
    output logic                   store_wr,
    output tensor_pkg::tensor_wr_t store_wr_req
);
    import tensor_pkg::*;

    localparam int LIN_W = 5 * `COORD_W;

    logic [LIN_W-1:0]    lin_cnt;   // Linear index of the current fill write
    tensor_coord_t       fill_coord;
    logic [`PIXEL_W-1:0] fill_pixel;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_busy <= 1'b0;
            lin_cnt   <= '0;
        end else if (fill_busy) begin
            lin_cnt <= lin_cnt + 1'b1;
            if (&lin_cnt) begin
                fill_busy <= 1'b0; // Last coordinate written this cycle
            end
        end else if (fill_start) begin
            fill_busy <= 1'b1;
            lin_cnt   <= '0;
        end
    end

    // Field order of the coordinate struct matches the linear index weights
    assign fill_coord = lin_cnt;
    assign fill_pixel = lin_cnt[`PIXEL_W-1:0] + fill_offset;

    // Host writes are dropped for the whole sweep
    assign store_wr = fill_busy | host_wr;

    always_comb begin
        if (fill_busy) begin
            store_wr_req.coord = fill_coord;
            store_wr_req.pixel = fill_pixel;
        end else begin
            store_wr_req = host_wr_req;
        end
    end

endmodule

/* src/tensor_store.sv */
// Video tensor store
// 4x4x4x4x4 pixel memory, one clocked write port, combinational window read
`timescale 1ns/1ps
`include "tensor_params.svh"

module tensor_store (
    input  logic                     clk,
    input  logic                     wr,
    input  tensor_pkg::tensor_wr_t   wr_req,
    input  tensor_pkg::tensor_coord_t rd_coord,
    output tensor_pkg::stencil_win_t win
);

    // [batch][frame][channel][row][col]
    logic [`PIXEL_W-1:0] mem [`TENSOR_DIM][`TENSOR_DIM][`TENSOR_DIM][`TENSOR_DIM][`TENSOR_DIM];

    // Neighbor indexes wrap at the edges
    logic [`COORD_W-1:0] row_up;
    logic [`COORD_W-1:0] row_dn;
    logic [`COORD_W-1:0] col_lt;
    logic [`COORD_W-1:0] col_rt;

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_req.coord.batch][wr_req.coord.frame][wr_req.coord.channel]
               [wr_req.coord.row][wr_req.coord.col] <= wr_req.pixel;
        end
    end

    assign row_up = rd_coord.row - 2'd1;
    assign row_dn = rd_coord.row + 2'd1;
    assign col_lt = rd_coord.col - 2'd1;
    assign col_rt = rd_coord.col + 2'd1;

    // Wrapped neighbors only matter off the interior, where the sum ignores them
    always_comb begin
        win.center = mem[rd_coord.batch][rd_coord.frame][rd_coord.channel]
                        [rd_coord.row][rd_coord.col];
        win.up     = mem[rd_coord.batch][rd_coord.frame][rd_coord.channel]
                        [row_up][rd_coord.col];
        win.down   = mem[rd_coord.batch][rd_coord.frame][rd_coord.channel]
                        [row_dn][rd_coord.col];
        win.left   = mem[rd_coord.batch][rd_coord.frame][rd_coord.channel]
                        [rd_coord.row][col_lt];
        win.right  = mem[rd_coord.batch][rd_coord.frame][rd_coord.channel]
                        [rd_coord.row][col_rt];
    end

endmodule

/* src/stencil_sum.sv */
// Read path with optional five-point spatial sum
// Registers the request, then the raw or summed result a cycle later
`timescale 1ns/1ps
`include "tensor_params.svh"

module stencil_sum (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rd_req,
    input  tensor_pkg::tensor_coord_t rd_coord,
    input  logic                      stencil_en,
    input  tensor_pkg::stencil_win_t  win,
    output tensor_pkg::tensor_coord_t win_coord,
    output logic                      rd_valid,
    output logic [`SUM_W-1:0]         rd_data
);
    import tensor_pkg::*;

    localparam int PAD_W = `SUM_W - `PIXEL_W;

    logic          req_q;
    tensor_coord_t coord_q;   // Held until the next request
    logic          interior;
    logic [`SUM_W-1:0] center_ext;
    logic [`SUM_W-1:0] five_sum;
    logic [`SUM_W-1:0] result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= rd_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            coord_q <= rd_coord;
        end
    end

    assign win_coord = coord_q;

    // Index 1 or 2 is exactly when the two bits differ
    assign interior = (coord_q.row[1] ^ coord_q.row[0]) & (coord_q.col[1] ^ coord_q.col[0]);

    assign center_ext = {{PAD_W{1'b0}}, win.center};
    assign five_sum   = center_ext
                      + {{PAD_W{1'b0}}, win.up}
                      + {{PAD_W{1'b0}}, win.down}
                      + {{PAD_W{1'b0}}, win.left}
                      + {{PAD_W{1'b0}}, win.right};

    // Edge pixels get no padding, just the center
    assign result = (stencil_en && interior) ? five_sum : center_ext;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
        end else begin
            rd_valid <= req_q;
            if (req_q) begin
                rd_data <= result;
            end
        end
    end

endmodule

/* src/video_tensor_top.sv */
// Batched video tensor buffer
// Config registers, fill engine, 5D store and stencil read path
`timescale 1ns/1ps

module video_tensor_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfg_wr,
    input  logic                      cfg_addr,
    input  logic [7:0]                cfg_wdata,
    input  logic                      fill_start,
    input  logic                      host_wr,
    input  tensor_pkg::tensor_wr_t    host_wr_req,
    input  logic                      rd_req,
    input  tensor_pkg::tensor_coord_t rd_coord,
    output logic                      fill_busy,
    output logic                      rd_valid,
    output logic [15:0]               rd_data
);
    import tensor_pkg::*;

    tensor_cfg_t   cfg;
    logic          store_wr;
    tensor_wr_t    store_wr_req;   // Pattern or host write
    tensor_coord_t win_coord;
    stencil_win_t  win;

    tensor_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    fill_engine u_fill_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .fill_start   (fill_start),
        .fill_offset  (cfg.fill_offset),
        .host_wr      (host_wr),
        .host_wr_req  (host_wr_req),
        .fill_busy    (fill_busy),
        .store_wr     (store_wr),
        .store_wr_req (store_wr_req)
    );

    tensor_store u_store (
        .clk      (clk),
        .wr       (store_wr),
        .wr_req   (store_wr_req),
        .rd_coord (win_coord),
        .win      (win)
    );

    // Read path sees the store through the registered coordinate
    stencil_sum u_stencil (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_req     (rd_req),
        .rd_coord   (rd_coord),
        .stencil_en (cfg.stencil_en),
        .win        (win),
        .win_coord  (win_coord),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

endmodule

/* test/video_tensor_properties.sv */
// Timing and reset properties of the video tensor top level
// Bound into video_tensor_top
`timescale 1ns/1ps

module video_tensor_properties (
    input logic clk,
    input logic rst_n,
    input logic rd_req,
    input logic rd_valid,
    input logic fill_busy
);

    int          fail_cnt = 0;
    logic [10:0] busy_cnt;   // Edges seen with fill_busy high

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (fill_busy) begin
            busy_cnt <= busy_cnt + 11'd1;
        end else begin
            busy_cnt <= '0;
        end
    end

    // Request sampled at one edge, result sampled two edges on
    valid_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rd_req, 2) |-> rd_valid)
        else begin
            fail_cnt++;
            $error("rd_valid missing after rd_req");
        end

    valid_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> $past(rd_req, 2))
        else begin
            fail_cnt++;
            $error("rd_valid without a matching rd_req");
        end

    fill_length: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(fill_busy) |-> busy_cnt == 11'd1024)
        else begin
            fail_cnt++;
            $error("fill_busy did not last 1024 cycles");
        end

    fill_not_longer: assert property (@(posedge clk) disable iff (!rst_n)
        fill_busy |-> busy_cnt < 11'd1024)
        else begin
            fail_cnt++;
            $error("fill_busy longer than 1024 cycles");
        end

    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !rd_valid && !fill_busy)
        else begin
            fail_cnt++;
            $error("rd_valid or fill_busy high right after reset");
        end

endmodule

bind video_tensor_top video_tensor_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_req    (rd_req),
    .rd_valid  (rd_valid),
    .fill_busy (fill_busy)
);

/* test/video_tensor_tb.sv */
// Testbench for the batched video tensor buffer
// Shadow model, immediate checks on every read result, one report line per test
`timescale 1ns/1ps

module video_tensor_tb;
    import tensor_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000; // Two fills of ~1030 cycles plus reads and writes
    localparam int FILL_LIMIT     = 1100;
    localparam int READ_LIMIT     = 4;

    logic          clk;
    logic          rst_n;
    logic          cfg_wr;
    logic          cfg_addr;
    logic [7:0]    cfg_wdata;
    logic          fill_start;
    logic          host_wr;
    tensor_wr_t    host_wr_req;
    logic          rd_req;
    tensor_coord_t rd_coord;
    logic          fill_busy;
    logic          rd_valid;
    logic [15:0]   rd_data;

    logic [7:0]    shadow [1024];   // Mirror of the store, by linear index
    tensor_cfg_t   shadow_cfg;
    logic [15:0]   exp_q [$];       // Expected results of reads in flight
    logic [15:0]   exp_data;
    tensor_coord_t dropped_q [$];   // Host writes issued during a fill
    logic          fill_running;
    int            cycles;
    int            checks;
    int            errors;
    int            test_checks;
    int            test_errors;

    video_tensor_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .fill_start  (fill_start),
        .host_wr     (host_wr),
        .host_wr_req (host_wr_req),
        .rd_req      (rd_req),
        .rd_coord    (rd_coord),
        .fill_busy   (fill_busy),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [9:0] lin_index(tensor_coord_t c);
        return 10'(c.batch) * 10'd256 + 10'(c.frame) * 10'd64 + 10'(c.channel) * 10'd16
             + 10'(c.row) * 10'd4 + 10'(c.col);
    endfunction

    function automatic logic [15:0] expected_value(tensor_coord_t c);
        logic [9:0] i;
        logic       interior;
        i        = lin_index(c);
        interior = (c.row == 2'd1 || c.row == 2'd2) && (c.col == 2'd1 || c.col == 2'd2);
        if (shadow_cfg.stencil_en && interior) begin
            return 16'(shadow[i]) + 16'(shadow[i - 10'd4]) + 16'(shadow[i + 10'd4])
                 + 16'(shadow[i - 10'd1]) + 16'(shadow[i + 10'd1]);
        end else begin
            return 16'(shadow[i]); // Center only
        end
    endfunction

    function automatic tensor_coord_t random_coord();
        return tensor_coord_t'(10'($urandom));
    endfunction

    function automatic tensor_coord_t interior_coord();
        tensor_coord_t c;
        c     = random_coord();
        c.row = 2'd1 + 2'($urandom_range(1));
        c.col = 2'd1 + 2'($urandom_range(1));
        return c;
    endfunction

    function automatic tensor_coord_t boundary_coord();
        tensor_coord_t c;
        c = random_coord();
        if ((c.row == 2'd1 || c.row == 2'd2) && (c.col == 2'd1 || c.col == 2'd2)) begin
            if ($urandom_range(1) == 0) begin
                c.row = ($urandom_range(1) == 0) ? 2'd0 : 2'd3;
            end else begin
                c.col = ($urandom_range(1) == 0) ? 2'd0 : 2'd3;
            end
        end
        return c;
    endfunction

    task automatic check_equal(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        checks++;
        assert (actual === expected) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
            errors++;
        end
    endtask

    // Every result is checked where rd_valid is stable
    always @(negedge clk) begin
        if (rd_valid) begin
            if (exp_q.size() == 0) begin
                $display("rd_valid was raised with no read pending");
                errors++;
            end else begin
                exp_data = exp_q.pop_front();
                check_equal("rd_data", rd_data, exp_data);
            end
        end
    end

    task automatic cfg_write(input logic addr, input logic [7:0] data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_wr = 1'b0;
        if (addr) shadow_cfg.fill_offset = data;
        else      shadow_cfg.stencil_en  = data[0];
    endtask

    task automatic host_write(input tensor_coord_t c, input logic [7:0] pix);
        host_wr           = 1'b1;
        host_wr_req.coord = c;
        host_wr_req.pixel = pix;
        @(posedge clk);
        #1;
        host_wr = 1'b0;
        if (fill_running) dropped_q.push_back(c); // Pattern wins
        else              shadow[lin_index(c)] = pix;
    endtask

    task automatic read_check(input tensor_coord_t c);
        int waited;
        waited = 0;
        exp_q.push_back(expected_value(c));
        rd_req   = 1'b1;
        rd_coord = c;
        @(posedge clk);
        #1;
        rd_req = 1'b0;
        while (!rd_valid && waited < READ_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!rd_valid) begin
            $display("No rd_valid came back for the read at linear index %0d", lin_index(c));
            errors++;
            exp_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic start_fill(input logic [7:0] offset);
        cfg_write(1'b1, offset);
        fill_start = 1'b1;
        @(posedge clk);
        #1;
        fill_start   = 1'b0;
        fill_running = 1'b1;
        for (int i = 0; i < 1024; i++) shadow[i] = 8'(i) + offset;
        if (!fill_busy) begin
            $display("fill_busy did not rise after fill_start");
            errors++;
        end
    endtask

    task automatic wait_fill_done();
        int waited;
        waited = 0;
        while (fill_busy && waited < FILL_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (fill_busy) begin
            $display("fill_busy stayed high for more than %0d cycles", FILL_LIMIT);
            errors++;
        end
        fill_running = 1'b0;
    endtask

    task automatic begin_test();
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        $display("%-22s %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        cfg_wr       = 1'b0;
        cfg_addr     = 1'b0;
        cfg_wdata    = 8'h00;
        fill_start   = 1'b0;
        host_wr      = 1'b0;
        host_wr_req  = '0;
        rd_req       = 1'b0;
        rd_coord     = '0;
        shadow_cfg   = '0;
        fill_running = 1'b0;
        cycles       = 0;
        checks       = 0;
        errors       = 0;
        void'($urandom(32'h7dfc));

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test();
        check_equal("rd_valid", 16'(rd_valid), 16'h0000);
        check_equal("fill_busy", 16'(fill_busy), 16'h0000);
        check_equal("rd_data", rd_data, 16'h0000);
        end_test("reset");

        begin_test();
        start_fill(8'h35);
        wait_fill_done();
        repeat (32) read_check(random_coord());
        end_test("pattern fill");

        begin_test();
        repeat (24) begin
            tensor_coord_t c;
            c = random_coord();
            host_write(c, 8'($urandom));
            read_check(c);
        end
        end_test("host write readback");

        begin_test();
        cfg_write(1'b0, 8'h01);
        repeat (16) read_check(interior_coord());
        end_test("interior stencil");

        begin_test();
        repeat (16) read_check(boundary_coord());
        cfg_write(1'b0, 8'h00);
        repeat (8) read_check(interior_coord());
        end_test("boundary and disable");

        begin_test();
        start_fill(8'h5a);
        repeat (64) @(posedge clk); // Sweep is past linear index 63 by now
        #1;
        repeat (16) begin
            tensor_coord_t c;
            c       = random_coord();
            c.batch = 2'd0;   // Already swept, so a leaked write would stick
            c.frame = 2'd0;
            host_write(c, ~shadow[lin_index(c)]);
        end
        wait_fill_done();
        while (dropped_q.size() > 0) read_check(dropped_q.pop_front());
        end_test("fill exclusivity");

        repeat (3) @(posedge clk);
        errors += UUT.u_props.fail_cnt;
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* video_tensor_top.f */
+incdir+src
src/tensor_pkg.sv
src/tensor_cfg_regs.sv
src/fill_engine.sv
src/tensor_store.sv
src/stencil_sum.sv
src/video_tensor_top.sv
test/video_tensor_properties.sv
test/video_tensor_tb.sv

/* Makefile */
TOP := video_tensor_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f video_tensor_top.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
